//--- Bender.yml
package:
  name: ccc_target

export_include_dirs:
  - verilog

sources:
  - verilog/ccc_target_pkg.sv
  - verilog/ddr_lane_ctrl.sv
  - verilog/ccc_target_engine.sv
  - verilog/ccc_regf.sv
  - verilog/ccc_target_top.sv
  - target: test
    files:
      - test/ccc_target_tb.sv

//--- files.f
+incdir+verilog
verilog/ccc_target_pkg.sv
verilog/ddr_lane_ctrl.sv
verilog/ccc_target_engine.sv
verilog/ccc_regf.sv
verilog/ccc_target_top.sv
test/ccc_target_tb.sv

//--- test/ccc_target_tb.sv
// ========================================
// Random CCC frames against a register model
// PHY strobes spaced 3 to 6 cycles, one frame per enable pulse
// ========================================
`timescale 1ns/10ps
`include "ccc_target_cfg.svh"

module ccc_target_tb;

  localparam int NUM_FRAMES = 200;
  localparam int MAX_CYCLES = NUM_FRAMES * 60 * 6;  // Frames x strobes x widest gap

  logic        i_sys_clk;
  logic        i_sys_rst;
  logic        i_engine_en;
  logic        i_bit_vld;
  logic        i_sda_bit;
  logic        o_sda_oe;
  logic        o_sda_out;
  logic        o_engine_done;
  logic [15:0] o_mwl;
  logic [15:0] o_mrl;
  logic [7:0]  o_event_en;
  logic [7:0]  o_rst_action;

  logic [15:0] exp_mwl;      // Model registers
  logic [15:0] exp_mrl;
  logic [7:0]  exp_evt;
  logic [7:0]  exp_rst;
  logic        ack_window;   // SDA drive allowed
  logic        tx_bits[$];   // Slots of the current frame
  int          done_cnt;
  int          cycle_cnt = 0;
  int          word_errs = 0;
  int          byte_errs = 0;
  int          pulse_errs = 0;
  int          drive_errs = 0;

  ccc_target_top dut (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_bit_vld     (i_bit_vld),
    .i_sda_bit     (i_sda_bit),
    .o_sda_oe      (o_sda_oe),
    .o_sda_out     (o_sda_out),
    .o_engine_done (o_engine_done),
    .o_mwl         (o_mwl),
    .o_mrl         (o_mrl),
    .o_event_en    (o_event_en),
    .o_rst_action  (o_rst_action)
  );

  initial begin
    i_sys_clk = 1'b0;
    forever #2 i_sys_clk = ~i_sys_clk;  // 4 ns period
  end

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%04h exp 0x%04h", name, got, exp);
      word_errs++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%02h exp 0x%02h", name, got, exp);
      byte_errs++;
    end
  endtask

  task automatic check_done(input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] o_engine_done pulses got 0x%0h exp 0x%0h", got, exp);
      pulse_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h exp 0x%0h", name, got, exp);
      drive_errs++;
    end
  endtask

  function automatic int rand_below(input int unsigned n);
    return int'($urandom % n);
  endfunction

  function automatic logic [7:0] rand8();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // Odd bits XOR on top, even bits XOR inverted below
  function automatic logic [1:0] calc_parity(input logic [15:0] word);
    logic odd_x;
    logic even_x;
    odd_x  = 1'b0;
    even_x = 1'b0;
    for (int b = 0; b < 16; b += 2) begin
      even_x = even_x ^ word[b];
      odd_x  = odd_x ^ word[b+1];
    end
    return {odd_x, ~even_x};
  endfunction

  function automatic logic is_supported(input logic [7:0] code);
    case (code)
      8'h00, 8'h80, 8'h01, 8'h81, 8'h09, 8'h89, 8'h0A, 8'h8A, 8'h2A, 8'h9A: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic takes_data(input logic [7:0] code);
    return (code == 8'h09 || code == 8'h89 || code == 8'h0A || code == 8'h8A);
  endfunction

  function automatic logic [7:0] pick_code(input int idx);
    case (idx)
      0: return 8'h00;
      1: return 8'h80;
      2: return 8'h01;
      3: return 8'h81;
      4: return 8'h09;
      5: return 8'h89;
      6: return 8'h0A;
      7: return 8'h8A;
      8: return 8'h2A;
      default: return 8'h9A;
    endcase
  endfunction

  // Register effect of a committed frame
  task automatic model_write(input logic [7:0] code, input logic [7:0] def,
                             input logic [15:0] data);
    case (code)
      8'h00, 8'h80: exp_evt = exp_evt | def;   // ENEC
      8'h01, 8'h81: exp_evt = exp_evt & ~def;  // DISEC
      8'h09, 8'h89: exp_mwl = data;
      8'h0A, 8'h8A: exp_mrl = data;
      default:      exp_rst = def;             // RSTACT
    endcase
  endtask

  task automatic push_bits(input logic [7:0] val, input int width);
    for (int b = width - 1; b >= 0; b--) begin
      tx_bits.push_back(val[b]);  // MSB first
    end
  endtask

  // One strobed slot, gap of 3 to 6 cycles to the next one
  task automatic send_slot(input logic b);
    int gap;
    gap = 3 + rand_below(4);
    @(posedge i_sys_clk);
    i_bit_vld <= 1'b1;
    i_sda_bit <= b;
    @(posedge i_sys_clk);
    i_bit_vld <= 1'b0;
    repeat (gap - 2) @(posedge i_sys_clk);
  endtask

  task automatic check_regs();
    check_word("o_mwl", o_mwl, exp_mwl);
    check_word("o_mrl", o_mrl, exp_mrl);
    check_byte("o_event_en", o_event_en, exp_evt);
    check_byte("o_rst_action", o_rst_action, exp_rst);
  endtask

  task automatic run_frame();
    logic [7:0]  code;
    logic [7:0]  def;
    logic [15:0] data;
    logic [7:0]  r8;
    logic [1:0]  pre_cmd;
    logic [1:0]  pre_dat;
    logic [1:0]  par_cmd;
    logic [1:0]  par_dat;
    logic        has_data;
    logic        supported;
    logic        ack_exp;
    logic        commit;
    int          err_kind;
    int          drop_at;
    int          wait_cnt;
    if (rand_below(5) == 0) begin
      do code = rand8(); while (is_supported(code));  // Unsupported or GET
    end else begin
      code = pick_code(rand_below(10));
    end
    def       = rand8();
    data      = {rand8(), rand8()};
    supported = is_supported(code);
    has_data  = takes_data(code);
    err_kind  = rand_below(10);  // 0..4 inject a fault
    if ((!has_data && (err_kind == 2 || err_kind == 3)) || (!supported && err_kind == 4)) begin
      err_kind = 9;
    end
    r8      = rand8();
    pre_cmd = `CCC_PRE_CMD;
    pre_dat = `CCC_PRE_DATA;
    par_cmd = calc_parity({code, def});
    par_dat = calc_parity(data);
    case (err_kind)
      0: pre_cmd = pre_cmd ^ ((r8[1:0] == 2'b00) ? 2'b11 : r8[1:0]);
      1: par_cmd = par_cmd ^ (r8[0] ? 2'b10 : 2'b01);
      2: pre_dat = pre_dat ^ ((r8[1:0] == 2'b00) ? 2'b11 : r8[1:0]);
      3: par_dat = par_dat ^ (r8[0] ? 2'b10 : 2'b01);
      default: ;
    endcase
    ack_exp = (err_kind != 0);
    commit  = supported && (err_kind >= 5);
    tx_bits.delete();
    push_bits({6'd0, pre_cmd}, 2);
    tx_bits.push_back(1'b0);  // Ack slot, target holds SDA low
    push_bits(code, 8);
    push_bits(def, 8);
    push_bits({6'd0, par_cmd}, 2);
    if (has_data) begin
      push_bits({6'd0, pre_dat}, 2);
      push_bits(data[15:8], 8);
      push_bits(data[7:0], 8);
      push_bits({6'd0, par_dat}, 2);
    end
    drop_at  = (err_kind == 4) ? 3 + rand_below(tx_bits.size() - 3) : -1;
    done_cnt = 0;
    @(posedge i_sys_clk);
    i_engine_en <= 1'b1;
    repeat (2) @(posedge i_sys_clk);
    for (int i = 0; i < tx_bits.size(); i++) begin
      if (i == drop_at) begin
        @(posedge i_sys_clk);
        i_engine_en <= 1'b0;  // Abort mid frame
      end
      if (i == 1) begin
        ack_window = ack_exp;
      end
      if (i == 2 && ack_exp) begin
        @(negedge i_sys_clk);
        check_bit("o_sda_oe", o_sda_oe, 1'b1);
        check_bit("o_sda_out", o_sda_out, 1'b0);
      end
      send_slot(tx_bits[i]);
      if (i == 2) begin
        ack_window = 1'b0;
      end
    end
    wait_cnt = 0;
    while (done_cnt == 0 && wait_cnt < 20) begin
      @(posedge i_sys_clk);
      wait_cnt++;
    end
    repeat (3) @(posedge i_sys_clk);  // Registers follow the write
    @(negedge i_sys_clk);
    check_done(done_cnt, 1);
    if (commit) begin
      model_write(code, def, data);
    end
    check_regs();
    @(posedge i_sys_clk);
    i_engine_en <= 1'b0;  // Rearm for the next frame
    repeat (2) @(posedge i_sys_clk);
  endtask

  // Done pulse count and stray SDA drive
  always @(negedge i_sys_clk) begin
    if (i_sys_rst) begin
      if (o_engine_done) begin
        done_cnt++;
      end
      if (o_sda_oe && !ack_window) begin
        check_bit("o_sda_oe", o_sda_oe, 1'b0);
      end
    end
  end

  always @(posedge i_sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: word %0d, byte %0d, done %0d, sda %0d",
               word_errs, byte_errs, pulse_errs, drive_errs);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int total;
    void'($urandom(89029));
    i_sys_rst   = 1'b0;
    i_engine_en = 1'b0;
    i_bit_vld   = 1'b0;
    i_sda_bit   = 1'b1;
    ack_window  = 1'b0;
    done_cnt    = 0;
    exp_mwl     = `CCC_MWL_RST;
    exp_mrl     = `CCC_MRL_RST;
    exp_evt     = `CCC_EVT_RST;
    exp_rst     = `CCC_RSTACT_RST;
    repeat (5) @(posedge i_sys_clk);
    i_sys_rst <= 1'b1;
    repeat (3) @(posedge i_sys_clk);
    @(negedge i_sys_clk);
    check_regs();  // Reset values
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame();
    end
    total = word_errs + byte_errs + pulse_errs + drive_errs;
    $display("Errors: word %0d, byte %0d, done %0d, sda %0d",
             word_errs, byte_errs, pulse_errs, drive_errs);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- verilog/ccc_regf.sv
// ========================================
// Single write port, outputs follow the write by one cycle
// ========================================
`timescale 1ns/10ps
`include "ccc_target_cfg.svh"

module ccc_regf (
  input  logic                     i_sys_clk,
  input  logic                     i_sys_rst,
  input  ccc_target_pkg::regf_wr_t i_wr,
  output logic [15:0]              o_mwl,
  output logic [15:0]              o_mrl,
  output logic [7:0]               o_event_en,
  output logic [7:0]               o_rst_action
);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_mwl        <= `CCC_MWL_RST;
      o_mrl        <= `CCC_MRL_RST;
      o_event_en   <= `CCC_EVT_RST;
      o_rst_action <= `CCC_RSTACT_RST;
    end else if (i_wr.wr_en) begin
      case (i_wr.addr)
        ccc_target_pkg::REG_EVENT_SET: begin
          o_event_en <= o_event_en | i_wr.data[7:0];  // ENEC sets
        end
        ccc_target_pkg::REG_EVENT_CLR: begin
          o_event_en <= o_event_en & ~i_wr.data[7:0];  // DISEC clears
        end
        ccc_target_pkg::REG_MWL: begin
          o_mwl <= i_wr.data;
        end
        ccc_target_pkg::REG_MRL: begin
          o_mrl <= i_wr.data;
        end
        ccc_target_pkg::REG_RSTACT: begin
          o_rst_action <= i_wr.data[7:0];  // Defining byte only
        end
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/ccc_target_cfg.svh
// ========================================
// Reset values and preamble codes for the CCC target
// Preamble codes are sent first bit first, MSB first
// ========================================
`ifndef CCC_TARGET_CFG_SVH
`define CCC_TARGET_CFG_SVH

// Register reset values
`define CCC_MWL_RST    16'h0100
`define CCC_MRL_RST    16'h0100
`define CCC_EVT_RST    8'h0B
`define CCC_RSTACT_RST 8'h00

// HDR-DDR word preambles
`define CCC_PRE_CMD    2'b01
`define CCC_PRE_DATA   2'b11

`endif

//--- verilog/ccc_target_engine.sv
// ========================================
// A new frame needs i_engine_en low then high again
// After an abort the PHY must finish the frame's slots
// ========================================
`timescale 1ns/10ps
`include "ccc_target_cfg.svh"

module ccc_target_engine (
  input  logic                         i_sys_clk,
  input  logic                         i_sys_rst,
  input  logic                         i_engine_en,
  input  logic                         i_mode_done,
  input  ccc_target_pkg::lane_result_t i_result,
  output logic                         o_mode_start,
  output ccc_target_pkg::lane_mode_e   o_mode,
  output ccc_target_pkg::regf_wr_t     o_regf_wr,
  output logic                         o_engine_done
);

  ccc_target_pkg::engine_state_e state_q, state_d;
  ccc_target_pkg::regf_addr_e    addr_q;     // Target of decoded code
  ccc_target_pkg::regf_addr_e    code_addr;
  logic       has_data_q;                    // SETMWL or SETMRL
  logic       code_data;
  logic       code_ok;
  logic       lane_pend_q;                   // Lane mode still open
  logic       armed_q;                       // Enable went low since last frame
  logic [7:0] ccc_q;
  logic [7:0] def_q;
  logic [7:0] hi_q;
  logic [7:0] lo_q;

  // Upper bit covers odd bits, lower bit covers even bits inverted
  function automatic logic [1:0] parity_pair(input logic [15:0] word);
    parity_pair = {^(word & 16'hAAAA), ~^(word & 16'h5555)};
  endfunction

  // Code decode on the incoming CCC byte
  always_comb begin
    code_ok   = 1'b1;
    code_data = 1'b0;
    code_addr = ccc_target_pkg::REG_EVENT_SET;
    case (i_result.data)
      ccc_target_pkg::ENEC_BC, ccc_target_pkg::ENEC_DIR: begin
        code_addr = ccc_target_pkg::REG_EVENT_SET;
      end
      ccc_target_pkg::DISEC_BC, ccc_target_pkg::DISEC_DIR: begin
        code_addr = ccc_target_pkg::REG_EVENT_CLR;
      end
      ccc_target_pkg::SETMWL_BC, ccc_target_pkg::SETMWL_DIR: begin
        code_addr = ccc_target_pkg::REG_MWL;
        code_data = 1'b1;
      end
      ccc_target_pkg::SETMRL_BC, ccc_target_pkg::SETMRL_DIR: begin
        code_addr = ccc_target_pkg::REG_MRL;
        code_data = 1'b1;
      end
      ccc_target_pkg::RSTACT_BC, ccc_target_pkg::RSTACT_DIR: begin
        code_addr = ccc_target_pkg::REG_RSTACT;
      end
      default: code_ok = 1'b0;  // GET and unknown codes
    endcase
  end

  // Next state, lane requests and writes
  always_comb begin
    state_d       = state_q;
    o_mode_start  = 1'b0;
    o_mode        = ccc_target_pkg::RX_PREAMBLE;
    o_regf_wr     = '0;
    o_engine_done = 1'b0;
    if (state_q != ccc_target_pkg::IDLE && !i_engine_en) begin
      o_engine_done = 1'b1;  // Abort, nothing written
      state_d       = ccc_target_pkg::IDLE;
    end else begin
      case (state_q)
        ccc_target_pkg::IDLE: begin
          if (i_engine_en && armed_q && (!lane_pend_q || i_mode_done)) begin
            o_mode_start = 1'b1;
            state_d      = ccc_target_pkg::PRE_CMD;
          end
        end
        ccc_target_pkg::PRE_CMD: begin
          if (i_mode_done) begin
            if (i_result.preamble == `CCC_PRE_CMD) begin
              o_mode_start = 1'b1;
              o_mode       = ccc_target_pkg::TX_ACK;
              state_d      = ccc_target_pkg::ACK;
            end else begin
              o_engine_done = 1'b1;
              state_d       = ccc_target_pkg::IDLE;
            end
          end
        end
        ccc_target_pkg::ACK: begin
          if (i_mode_done) begin
            o_mode_start = 1'b1;
            o_mode       = ccc_target_pkg::RX_BYTE;
            state_d      = ccc_target_pkg::CCC_CODE;
          end
        end
        ccc_target_pkg::CCC_CODE: begin
          if (i_mode_done) begin
            if (code_ok) begin
              o_mode_start = 1'b1;
              o_mode       = ccc_target_pkg::RX_BYTE;
              state_d      = ccc_target_pkg::DEF_BYTE;
            end else begin
              o_engine_done = 1'b1;  // Unsupported code
              state_d       = ccc_target_pkg::IDLE;
            end
          end
        end
        ccc_target_pkg::DEF_BYTE: begin
          if (i_mode_done) begin
            o_mode_start = 1'b1;
            o_mode       = ccc_target_pkg::RX_PARITY;
            state_d      = ccc_target_pkg::CMD_PARITY;
          end
        end
        ccc_target_pkg::CMD_PARITY: begin
          if (i_mode_done) begin
            if (parity_pair({ccc_q, def_q}) != i_result.parity) begin
              o_engine_done = 1'b1;
              state_d       = ccc_target_pkg::IDLE;
            end else if (has_data_q) begin
              o_mode_start = 1'b1;
              state_d      = ccc_target_pkg::PRE_DATA;  // Data word follows
            end else begin
              o_regf_wr.wr_en = 1'b1;
              o_regf_wr.addr  = addr_q;
              o_regf_wr.data  = {8'h00, def_q};
              o_engine_done   = 1'b1;
              state_d         = ccc_target_pkg::IDLE;
            end
          end
        end
        ccc_target_pkg::PRE_DATA: begin
          if (i_mode_done) begin
            if (i_result.preamble == `CCC_PRE_DATA) begin
              o_mode_start = 1'b1;
              o_mode       = ccc_target_pkg::RX_BYTE;
              state_d      = ccc_target_pkg::DATA_HI;
            end else begin
              o_engine_done = 1'b1;
              state_d       = ccc_target_pkg::IDLE;
            end
          end
        end
        ccc_target_pkg::DATA_HI: begin
          if (i_mode_done) begin
            o_mode_start = 1'b1;
            o_mode       = ccc_target_pkg::RX_BYTE;
            state_d      = ccc_target_pkg::DATA_LO;
          end
        end
        ccc_target_pkg::DATA_LO: begin
          if (i_mode_done) begin
            o_mode_start = 1'b1;
            o_mode       = ccc_target_pkg::RX_PARITY;
            state_d      = ccc_target_pkg::DATA_PARITY;
          end
        end
        ccc_target_pkg::DATA_PARITY: begin
          if (i_mode_done) begin
            if (parity_pair({hi_q, lo_q}) == i_result.parity) begin
              o_regf_wr.wr_en = 1'b1;
              o_regf_wr.addr  = addr_q;
              o_regf_wr.data  = {hi_q, lo_q};  // MSB byte first on the wire
            end
            o_engine_done = 1'b1;
            state_d       = ccc_target_pkg::IDLE;
          end
        end
        default: state_d = ccc_target_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q     <= ccc_target_pkg::IDLE;
      lane_pend_q <= 1'b0;
      armed_q     <= 1'b1;
    end else begin
      state_q <= state_d;
      if (o_mode_start) begin
        lane_pend_q <= 1'b1;
      end else if (i_mode_done) begin
        lane_pend_q <= 1'b0;
      end
      if (!i_engine_en) begin
        armed_q <= 1'b1;  // Ready for the next frame
      end else if (state_q == ccc_target_pkg::IDLE && o_mode_start) begin
        armed_q <= 1'b0;
      end
    end
  end

  // Frame payload, captured on each lane done
  always_ff @(posedge i_sys_clk) begin
    if (i_mode_done) begin
      case (state_q)
        ccc_target_pkg::CCC_CODE: begin
          ccc_q      <= i_result.data;
          addr_q     <= code_addr;
          has_data_q <= code_data;
        end
        ccc_target_pkg::DEF_BYTE: def_q <= i_result.data;
        ccc_target_pkg::DATA_HI:  hi_q  <= i_result.data;
        ccc_target_pkg::DATA_LO:  lo_q  <= i_result.data;
        default: ;
      endcase
    end
  end

  // Every write closes its frame
  a_wr_with_done: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_regf_wr.wr_en |-> o_engine_done ##1 (state_q == ccc_target_pkg::IDLE))
    else $error("register write outside frame end");

endmodule

//--- verilog/ccc_target_pkg.sv
// ========================================
// Shared types of the CCC target engine
// Direct codes reuse the broadcast register targets
// ========================================
package ccc_target_pkg;

  typedef enum logic [2:0] {
    RX_PREAMBLE = 3'd0,  // Two preamble bits
    RX_BYTE     = 3'd1,  // Eight data bits, MSB first
    RX_PARITY   = 3'd2,  // Two parity bits
    TX_ACK      = 3'd3   // One driven low slot
  } lane_mode_e;

  typedef enum logic [3:0] {
    IDLE        = 4'd0,
    PRE_CMD     = 4'd1,
    ACK         = 4'd2,
    CCC_CODE    = 4'd3,
    DEF_BYTE    = 4'd4,
    CMD_PARITY  = 4'd5,
    PRE_DATA    = 4'd6,
    DATA_HI     = 4'd7,
    DATA_LO     = 4'd8,
    DATA_PARITY = 4'd9
  } engine_state_e;

  typedef enum logic [7:0] {
    ENEC_BC    = 8'h00,
    DISEC_BC   = 8'h01,
    SETMWL_BC  = 8'h09,
    SETMRL_BC  = 8'h0A,
    RSTACT_BC  = 8'h2A,
    ENEC_DIR   = 8'h80,
    DISEC_DIR  = 8'h81,
    SETMWL_DIR = 8'h89,
    SETMRL_DIR = 8'h8A,
    RSTACT_DIR = 8'h9A
  } ccc_code_e;

  typedef enum logic [2:0] {
    REG_EVENT_SET = 3'd0,  // OR into event enables
    REG_EVENT_CLR = 3'd1,  // Clear event enables
    REG_MWL       = 3'd2,
    REG_MRL       = 3'd3,
    REG_RSTACT    = 3'd4
  } regf_addr_e;

  typedef struct packed {
    logic [1:0] preamble;  // Valid for RX_PREAMBLE
    logic [7:0] data;      // Valid for RX_BYTE
    logic [1:0] parity;    // Valid for RX_PARITY, first bit in [1]
  } lane_result_t;

  typedef struct packed {
    logic        wr_en;
    regf_addr_e  addr;
    logic [15:0] data;
  } regf_wr_t;

endpackage

//--- verilog/ccc_target_top.sv
// ========================================
// CCC target: lane, frame engine, register file
// ========================================
`timescale 1ns/10ps

module ccc_target_top (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_engine_en,
  input  logic        i_bit_vld,
  input  logic        i_sda_bit,
  output logic        o_sda_oe,
  output logic        o_sda_out,
  output logic        o_engine_done,
  output logic [15:0] o_mwl,
  output logic [15:0] o_mrl,
  output logic [7:0]  o_event_en,
  output logic [7:0]  o_rst_action
);

  ccc_target_pkg::lane_mode_e   lane_mode;
  ccc_target_pkg::lane_result_t lane_result;
  ccc_target_pkg::regf_wr_t     regf_wr;
  logic                         lane_start;
  logic                         lane_done;

  ddr_lane_ctrl u_lane (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_bit_vld    (i_bit_vld),
    .i_sda_bit    (i_sda_bit),
    .i_mode_start (lane_start),
    .i_mode       (lane_mode),
    .o_mode_done  (lane_done),
    .o_result     (lane_result),
    .o_sda_oe     (o_sda_oe),
    .o_sda_out    (o_sda_out)
  );

  ccc_target_engine u_engine (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_mode_done   (lane_done),
    .i_result      (lane_result),
    .o_mode_start  (lane_start),
    .o_mode        (lane_mode),
    .o_regf_wr     (regf_wr),
    .o_engine_done (o_engine_done)
  );

  ccc_regf u_regf (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_wr         (regf_wr),
    .o_mwl        (o_mwl),
    .o_mrl        (o_mrl),
    .o_event_en   (o_event_en),
    .o_rst_action (o_rst_action)
  );

endmodule

//--- verilog/ddr_lane_ctrl.sv
// ========================================
// Strobes must be at least 3 cycles apart
// Strobes while idle are ignored; no parity check here
// ========================================
`timescale 1ns/10ps

module ddr_lane_ctrl (
  input  logic                         i_sys_clk,
  input  logic                         i_sys_rst,
  input  logic                         i_bit_vld,
  input  logic                         i_sda_bit,
  input  logic                         i_mode_start,
  input  ccc_target_pkg::lane_mode_e   i_mode,
  output logic                         o_mode_done,
  output ccc_target_pkg::lane_result_t o_result,
  output logic                         o_sda_oe,
  output logic                         o_sda_out
);

  ccc_target_pkg::lane_mode_e mode_q;  // Mode being served
  logic       busy_q;                  // Mode in progress
  logic [2:0] bit_cnt_q;               // Slots taken so far
  logic [2:0] last_idx;                // Index of final slot
  logic [7:0] shift_q;                 // Deserializer
  logic       last_bit;
  logic       rx_mode;

  // Final slot index per mode
  always_comb begin
    case (mode_q)
      ccc_target_pkg::RX_PREAMBLE: last_idx = 3'd1;
      ccc_target_pkg::RX_BYTE:     last_idx = 3'd7;
      ccc_target_pkg::RX_PARITY:   last_idx = 3'd1;
      default:                     last_idx = 3'd0;  // TX_ACK is one slot
    endcase
  end

  assign last_bit = busy_q && i_bit_vld && (bit_cnt_q == last_idx);
  assign rx_mode  = (mode_q != ccc_target_pkg::TX_ACK);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      busy_q      <= 1'b0;
      mode_q      <= ccc_target_pkg::RX_PREAMBLE;
      bit_cnt_q   <= 3'd0;
      o_mode_done <= 1'b0;
      o_sda_oe    <= 1'b0;
    end else begin
      o_mode_done <= last_bit;  // One cycle after final strobe
      if (i_mode_start) begin
        busy_q    <= 1'b1;
        mode_q    <= i_mode;
        bit_cnt_q <= 3'd0;
        o_sda_oe  <= (i_mode == ccc_target_pkg::TX_ACK);  // Drive from next cycle
      end else if (busy_q && i_bit_vld) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
        if (last_bit) begin
          busy_q   <= 1'b0;
          o_sda_oe <= 1'b0;  // Release after ack slot
        end
      end
    end
  end

  // First received bit ends up as MSB
  always_ff @(posedge i_sys_clk) begin
    if (busy_q && i_bit_vld && rx_mode) begin
      shift_q <= {shift_q[6:0], i_sda_bit};
    end
  end

  assign o_sda_out = ~o_sda_oe;  // Low during ack, idle high otherwise

  // Pack only the field of the mode that ended
  always_comb begin
    o_result = '0;
    case (mode_q)
      ccc_target_pkg::RX_PREAMBLE: o_result.preamble = shift_q[1:0];
      ccc_target_pkg::RX_BYTE:     o_result.data     = shift_q;
      ccc_target_pkg::RX_PARITY:   o_result.parity   = shift_q[1:0];
      default:                     o_result          = '0;
    endcase
  end

  // Engine must wait for done before the next start
  a_no_start_busy: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_mode_start |-> !busy_q)
    else $error("lane start while busy");

  // SDA is only ever driven for the ack slot
  a_oe_only_ack: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_sda_oe |-> (busy_q && mode_q == ccc_target_pkg::TX_ACK))
    else $error("SDA driven outside TX_ACK");

endmodule
